/* Makefile */
# Verilator build and run of the pipeline testbench

VERILATOR ?= verilator
TOP       ?= coreTb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_TEXT ?= STATUS: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* build.f */
src/isaPkg.sv
src/pipeDefsPkg.sv
src/decodedOpIf.sv
src/instrFifo.sv
src/registerFile.sv
src/decodeStage.sv
src/executeStage.sv
src/resultStage.sv
src/mipsCore.sv
testbench/coreTb.sv

/* src/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage import isaPkg::*, pipeDefsPkg::*; #(
    parameter int FifoDepth = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic instrValid,
    input  logic [WordWidth-1:0] instr,
    input  logic advance,
    output logic instrCredit,
    input  logic wbEnable,
    input  logic [RegIdxWidth-1:0] wbReg,
    input  logic [WordWidth-1:0] wbData,
    decodedOpIf.decode decOut
);

    logic queueEmpty;
    logic [WordWidth-1:0] queueHead;
    logic pop;
    instrWord word;
    logic [WordWidth-1:0] valueA;
    logic [WordWidth-1:0] valueB;

    // Decoded fields for the next decode register load
    logic known;
    logic [AluOpWidth-1:0] aluOp;
    logic [WordWidth-1:0] operandA;
    logic [WordWidth-1:0] operandB;
    logic [RegIdxWidth-1:0] srcA;
    logic [RegIdxWidth-1:0] destReg;
    logic usesSrcB;

    instrFifo #(.FifoDepth(FifoDepth)) instrQueue (
        .clk(clk),
        .reset(reset),
        .pushValid(instrValid),
        .pushData(instr),
        .pop(pop),
        .empty(queueEmpty),
        .head(queueHead)
    );

    assign word = queueHead;

    // rs and rt read straight from the queue head
    registerFile regFile (
        .clk(clk),
        .reset(reset),
        .readA(word.rType.rs),
        .readB(word.rType.rt),
        .valueA(valueA),
        .valueB(valueB),
        .writeEnable(wbEnable),
        .writeReg(wbReg),
        .writeData(wbData)
    );

    // Take one word per advance, bubble if queue is empty
    assign pop = advance && !queueEmpty;

    always_comb begin
        known = 1'b1;
        aluOp = AluAdd;
        operandA = valueA;
        operandB = '0;
        srcA = word.rType.rs;
        destReg = word.iType.rt;
        usesSrcB = 1'b0;
        case (word.rType.opcode)
            OpcodeRtype: begin
                destReg = word.rType.rd;
                operandB = valueB;
                usesSrcB = 1'b1;
                case (word.rType.funct)
                    FunctAdd: aluOp = AluAdd;
                    FunctSub: aluOp = AluSub;
                    FunctAnd: aluOp = AluAnd;
                    FunctOr:  aluOp = AluOr;
                    FunctXor: aluOp = AluXor;
                    FunctSlt: aluOp = AluSlt;
                    FunctSll, FunctSrl: begin
                        // Shift rt by shamt; rt moves to the A side
                        aluOp = (word.rType.funct == FunctSll) ? AluSll : AluSrl;
                        operandA = valueB;
                        srcA = word.rType.rt;
                        operandB = WordWidth'(word.rType.shamt);
                        usesSrcB = 1'b0;
                    end
                    default: known = 1'b0;
                endcase
            end
            // Sign-extended immediate
            OpAddi: begin
                aluOp = AluAdd;
                operandB = {{(WordWidth - 16){word.iType.imm[15]}}, word.iType.imm};
            end
            // Logical immediates are zero-extended
            OpAndi: begin
                aluOp = AluAnd;
                operandB = WordWidth'(word.iType.imm);
            end
            OpOri: begin
                aluOp = AluOr;
                operandB = WordWidth'(word.iType.imm);
            end
            OpLui: begin
                aluOp = AluLui;
                operandB = WordWidth'(word.iType.imm);
            end
            default: known = 1'b0;
        endcase
    end

    // Control; unknown words still return their credit
    always_ff @(posedge clk) begin
        if (reset) begin
            decOut.valid <= 1'b0;
            instrCredit <= 1'b0;
        end else begin
            instrCredit <= pop;
            if (advance) begin
                decOut.valid <= pop && known;
            end
        end
    end

    // Decode register payload
    always_ff @(posedge clk) begin
        if (advance) begin
            decOut.aluOp <= aluOp;
            decOut.operandA <= operandA;
            decOut.operandB <= operandB;
            decOut.srcA <= srcA;
            decOut.srcB <= word.rType.rt;
            decOut.destReg <= destReg;
            decOut.usesSrcB <= usesSrcB;
        end
    end

endmodule

/* src/decodedOpIf.sv */
`timescale 1ns/1ps

interface decodedOpIf import isaPkg::*, pipeDefsPkg::*; ();

    // Bubble marker
    logic valid;
    logic [AluOpWidth-1:0] aluOp;

    // Operand values as read in decode
    logic [WordWidth-1:0] operandA;
    logic [WordWidth-1:0] operandB;

    // Source registers for forwarding match
    logic [RegIdxWidth-1:0] srcA;
    logic [RegIdxWidth-1:0] srcB;
    logic usesSrcB;

    logic [RegIdxWidth-1:0] destReg;

    modport decode(
        output valid, aluOp, operandA, operandB, srcA, srcB, destReg, usesSrcB
    );

    modport execute(
        input valid, aluOp, operandA, operandB, srcA, srcB, destReg, usesSrcB
    );

endinterface

/* src/executeStage.sv */
`timescale 1ns/1ps

module executeStage import isaPkg::*, pipeDefsPkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic advance,
    decodedOpIf.execute decIn,
    input  logic fwdValid,
    input  logic [RegIdxWidth-1:0] fwdReg,
    input  logic [WordWidth-1:0] fwdValue,
    output logic exValid,
    output logic [RegIdxWidth-1:0] exDest,
    output logic [WordWidth-1:0] exValue
);

    logic fwdHit;
    logic [WordWidth-1:0] opA;
    logic [WordWidth-1:0] opB;
    logic [WordWidth-1:0] aluResult;

    // Register 0 result never forwarded
    assign fwdHit = fwdValid && fwdReg != '0;
    assign opA = (fwdHit && fwdReg == decIn.srcA) ? fwdValue : decIn.operandA;
    // B only for register-register ops
    assign opB = (fwdHit && decIn.usesSrcB && fwdReg == decIn.srcB) ?
                 fwdValue : decIn.operandB;

    always_comb begin
        case (decIn.aluOp)
            AluAdd: aluResult = opA + opB;
            AluSub: aluResult = opA - opB;
            AluAnd: aluResult = opA & opB;
            AluOr:  aluResult = opA | opB;
            AluXor: aluResult = opA ^ opB;
            // Signed compare
            AluSlt: aluResult = WordWidth'($signed(opA) < $signed(opB));
            AluSll: aluResult = opA << opB[4:0];
            AluSrl: aluResult = opA >> opB[4:0];
            AluLui: aluResult = {opB[15:0], 16'h0000};
            default: aluResult = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exValid <= 1'b0;
        end else if (advance) begin
            exValid <= decIn.valid;
        end
    end

    // Execute register payload
    always_ff @(posedge clk) begin
        if (advance) begin
            exDest <= decIn.destReg;
            exValue <= aluResult;
        end
    end

endmodule

/* src/instrFifo.sv */
`timescale 1ns/1ps

module instrFifo import isaPkg::*; #(
    parameter int FifoDepth = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic pushValid,
    input  logic [WordWidth-1:0] pushData,
    input  logic pop,
    output logic empty,
    output logic [WordWidth-1:0] head
);

    localparam int PtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
    localparam int CountWidth = $clog2(FifoDepth + 1);

    logic [WordWidth-1:0] slots [FifoDepth];
    logic [PtrWidth-1:0] readPtr;
    logic [PtrWidth-1:0] writePtr;
    logic [CountWidth-1:0] count;

    // Wrap at depth, which need not be a power of two
    function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
        if (ptr == PtrWidth'(FifoDepth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            readPtr <= '0;
            writePtr <= '0;
            count <= '0;
        end else begin
            if (pushValid) begin
                writePtr <= nextPtr(writePtr);
            end
            if (pop) begin
                readPtr <= nextPtr(readPtr);
            end
            // Push and pop in one cycle cancel out
            count <= count + CountWidth'(pushValid) - CountWidth'(pop);
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (pushValid) begin
            slots[writePtr] <= pushData;
        end
    end

    assign empty = (count == '0);
    assign head = slots[readPtr];

endmodule

/* src/isaPkg.sv */
package isaPkg;

    // Word and register index widths
    localparam int WordWidth = 32;
    localparam int RegIdxWidth = 5;

    // Major opcodes
    localparam logic [5:0] OpcodeRtype = 6'h00;
    localparam logic [5:0] OpAddi = 6'h08;
    localparam logic [5:0] OpAndi = 6'h0C;
    localparam logic [5:0] OpOri = 6'h0D;
    localparam logic [5:0] OpLui = 6'h0F;

    // R-type funct codes
    localparam logic [5:0] FunctSll = 6'h00;
    localparam logic [5:0] FunctSrl = 6'h02;
    localparam logic [5:0] FunctAdd = 6'h20;
    localparam logic [5:0] FunctSub = 6'h22;
    localparam logic [5:0] FunctAnd = 6'h24;
    localparam logic [5:0] FunctOr = 6'h25;
    localparam logic [5:0] FunctXor = 6'h26;
    localparam logic [5:0] FunctSlt = 6'h2A;

    // One instruction word, seen as R-type or I-type fields
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [RegIdxWidth-1:0] rs;
            logic [RegIdxWidth-1:0] rt;
            logic [RegIdxWidth-1:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } rType;
        struct packed {
            logic [5:0] opcode;
            logic [RegIdxWidth-1:0] rs;
            logic [RegIdxWidth-1:0] rt;
            logic [15:0] imm;
        } iType;
    } instrWord;

endpackage

/* src/mipsCore.sv */
`timescale 1ns/1ps

module mipsCore import isaPkg::*; #(
    parameter int FifoDepth = 4,
    parameter int ResultCredits = 2
) (
    input  logic clk,
    input  logic reset,
    input  logic instrValid,
    input  logic [WordWidth-1:0] instr,
    output logic instrCredit,
    output logic resultValid,
    output logic [RegIdxWidth-1:0] resultReg,
    output logic [WordWidth-1:0] resultData,
    input  logic resultCreditReturn
);

    // Stall from result stage
    logic advance;

    // Execute register to result stage
    logic exValid;
    logic [RegIdxWidth-1:0] exDest;
    logic [WordWidth-1:0] exValue;

    // Forwarding path back into execute
    logic fwdValid;
    logic [RegIdxWidth-1:0] fwdReg;
    logic [WordWidth-1:0] fwdValue;

    // Register file write port
    logic wbEnable;
    logic [RegIdxWidth-1:0] wbReg;
    logic [WordWidth-1:0] wbData;

    decodedOpIf decodedOp ();

    decodeStage #(.FifoDepth(FifoDepth)) decodeUnit (
        .clk(clk),
        .reset(reset),
        .instrValid(instrValid),
        .instr(instr),
        .advance(advance),
        .instrCredit(instrCredit),
        .wbEnable(wbEnable),
        .wbReg(wbReg),
        .wbData(wbData),
        .decOut(decodedOp.decode)
    );

    executeStage executeUnit (
        .clk(clk),
        .reset(reset),
        .advance(advance),
        .decIn(decodedOp.execute),
        .fwdValid(fwdValid),
        .fwdReg(fwdReg),
        .fwdValue(fwdValue),
        .exValid(exValid),
        .exDest(exDest),
        .exValue(exValue)
    );

    resultStage #(.ResultCredits(ResultCredits)) resultUnit (
        .clk(clk),
        .reset(reset),
        .exValid(exValid),
        .exDest(exDest),
        .exValue(exValue),
        .resultCreditReturn(resultCreditReturn),
        .advance(advance),
        .resultValid(resultValid),
        .resultReg(resultReg),
        .resultData(resultData),
        .fwdValid(fwdValid),
        .fwdReg(fwdReg),
        .fwdValue(fwdValue),
        .wbEnable(wbEnable),
        .wbReg(wbReg),
        .wbData(wbData)
    );

endmodule

/* src/pipeDefsPkg.sv */
package pipeDefsPkg;

    // ALU operation code width
    localparam int AluOpWidth = 4;

    // Arithmetic
    localparam logic [AluOpWidth-1:0] AluAdd = 4'd0;
    localparam logic [AluOpWidth-1:0] AluSub = 4'd1;
    localparam logic [AluOpWidth-1:0] AluSlt = 4'd5;

    // Bitwise logic
    localparam logic [AluOpWidth-1:0] AluAnd = 4'd2;
    localparam logic [AluOpWidth-1:0] AluOr = 4'd3;
    localparam logic [AluOpWidth-1:0] AluXor = 4'd4;

    // Shifts, amount taken from operand B
    localparam logic [AluOpWidth-1:0] AluSll = 4'd6;
    localparam logic [AluOpWidth-1:0] AluSrl = 4'd7;

    // Immediate into the upper half
    localparam logic [AluOpWidth-1:0] AluLui = 4'd8;

endpackage

/* src/registerFile.sv */
`timescale 1ns/1ps

module registerFile import isaPkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic [RegIdxWidth-1:0] readA,
    input  logic [RegIdxWidth-1:0] readB,
    output logic [WordWidth-1:0] valueA,
    output logic [WordWidth-1:0] valueB,
    input  logic writeEnable,
    input  logic [RegIdxWidth-1:0] writeReg,
    input  logic [WordWidth-1:0] writeData
);

    logic [WordWidth-1:0] regs [32];

    // Register 0 never written, so it stays zero after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeReg != '0) begin
            regs[writeReg] <= writeData;
        end
    end

    // Same-cycle write shows up on the read ports
    assign valueA = (writeEnable && writeReg != '0 && writeReg == readA) ?
                    writeData : regs[readA];
    assign valueB = (writeEnable && writeReg != '0 && writeReg == readB) ?
                    writeData : regs[readB];

endmodule

/* src/resultStage.sv */
`timescale 1ns/1ps

module resultStage import isaPkg::*; #(
    parameter int ResultCredits = 2
) (
    input  logic clk,
    input  logic reset,
    input  logic exValid,
    input  logic [RegIdxWidth-1:0] exDest,
    input  logic [WordWidth-1:0] exValue,
    input  logic resultCreditReturn,
    output logic advance,
    output logic resultValid,
    output logic [RegIdxWidth-1:0] resultReg,
    output logic [WordWidth-1:0] resultData,
    output logic fwdValid,
    output logic [RegIdxWidth-1:0] fwdReg,
    output logic [WordWidth-1:0] fwdValue,
    output logic wbEnable,
    output logic [RegIdxWidth-1:0] wbReg,
    output logic [WordWidth-1:0] wbData
);

    localparam int CreditWidth = $clog2(ResultCredits + 1);

    logic [CreditWidth-1:0] creditCount;
    logic haveCredit;

    assign haveCredit = (creditCount != '0);

    // Only a held item without credit stalls the pipe
    assign advance = !exValid || haveCredit;
    assign resultValid = exValid && haveCredit;
    assign resultReg = exDest;
    assign resultData = exValue;

    // Held item stays a forwarding source while stalled
    assign fwdValid = exValid;
    assign fwdReg = exDest;
    assign fwdValue = exValue;

    // Write back only when the result leaves
    assign wbEnable = resultValid;
    assign wbReg = exDest;
    assign wbData = exValue;

    // Return and spend in one cycle leave the count unchanged
    always_ff @(posedge clk) begin
        if (reset) begin
            creditCount <= CreditWidth'(ResultCredits);
        end else begin
            creditCount <= creditCount + CreditWidth'(resultCreditReturn)
                           - CreditWidth'(resultValid);
        end
    end

endmodule

/* testbench/coreTb.sv */
`timescale 1ns/1ps

module coreTb import isaPkg::*; ();

    localparam int FifoDepth = 4;
    localparam int ResultCredits = 2;
    localparam int ClockPeriod = 100;
    localparam int DriveDelay = 5;
    localparam int WaitLimit = 500;
    // Last pop to result, with margin
    localparam int PipeSettle = 4;

    logic clk;
    logic reset;
    logic instrValid;
    logic [WordWidth-1:0] instr;
    logic instrCredit;
    logic resultValid;
    logic [RegIdxWidth-1:0] resultReg;
    logic [WordWidth-1:0] resultData;
    logic resultCreditReturn;

    // Current test from the data file
    logic [8*24-1:0] testName;
    int holdCycles;
    logic [WordWidth-1:0] instrList [$];
    logic [RegIdxWidth-1:0] expRegs [$];
    logic [WordWidth-1:0] expValues [$];

    // Owned by the main process
    int sentTotal;
    bit holdCredits;
    bit timedOut;
    int errorCount;
    int testsRun;
    int testsFailed;

    // Owned by the output monitor
    logic [RegIdxWidth-1:0] gotRegs [$];
    logic [WordWidth-1:0] gotValues [$];
    int resultsTotal = 0;
    int creditTotal = 0;
    int returnsSeen = 0;
    int protocolErrors = 0;

    mipsCore #(
        .FifoDepth(FifoDepth),
        .ResultCredits(ResultCredits)
    ) mipsCore_inst (
        .clk(clk),
        .reset(reset),
        .instrValid(instrValid),
        .instr(instr),
        .instrCredit(instrCredit),
        .resultValid(resultValid),
        .resultReg(resultReg),
        .resultData(resultData),
        .resultCreditReturn(resultCreditReturn)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(ClockPeriod / 2) clk = ~clk;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Outputs are sampled on the edge, before the DUT updates
    always @(posedge clk) begin
        if (!reset) begin
            if (resultValid) begin
                gotRegs.push_back(resultReg);
                gotValues.push_back(resultData);
                resultsTotal++;
            end
            if (resultCreditReturn) begin
                returnsSeen++;
            end
            if (instrCredit) begin
                creditTotal++;
                if (creditTotal > sentTotal) begin
                    protocolErrors++;
                    $display("ERROR at %0t: instruction credit with no word outstanding", $time);
                end
            end
        end
    end

    // Consumer, returns each result credit after a random gap
    initial begin
        logic [31:0] rngState;
        int returnWait;
        int returnedTotal;
        bit holding;
        rngState = 32'd51200;
        returnWait = 0;
        returnedTotal = 0;
        resultCreditReturn = 1'b0;
        forever begin
            @(posedge clk);
            holding = holdCredits;
            #DriveDelay;
            resultCreditReturn = 1'b0;
            if (returnWait > 0) begin
                returnWait--;
            end else if (resultsTotal > returnedTotal && !holding) begin
                resultCreditReturn = 1'b1;
                returnedTotal++;
                rngState = xorshift(rngState);
                returnWait = int'(rngState[1:0]);
            end
        end
    end

    task automatic reportFailure(input string what);
        errorCount++;
        $display("ERROR at %0t: %0s", $time, what);
    endtask

    task automatic reportTimeout(input string what);
        timedOut = 1'b1;
        reportFailure($sformatf("timeout, %0s", what));
    endtask

    task automatic checkReg(input string signalName, input logic [RegIdxWidth-1:0] expected,
                            input logic [RegIdxWidth-1:0] actual);
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH at %0t: %0s expected %0d got %0d",
                     $time, signalName, expected, actual);
        end
    endtask

    task automatic checkWord(input string signalName, input logic [WordWidth-1:0] expected,
                             input logic [WordWidth-1:0] actual);
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH at %0t: %0s expected %08h got %08h",
                     $time, signalName, expected, actual);
        end
    endtask

    // One word per cycle while a credit is held
    task automatic sendWords();
        int waited;
        foreach (instrList[i]) begin
            waited = 0;
            while (sentTotal - creditTotal >= FifoDepth) begin
                @(posedge clk);
                #DriveDelay;
                waited++;
                if (waited > WaitLimit) begin
                    reportTimeout("no instruction credit came back");
                    return;
                end
            end
            instrValid = 1'b1;
            instr = instrList[i];
            sentTotal++;
            @(posedge clk);
            #DriveDelay;
            instrValid = 1'b0;
        end
    endtask

    // Fixed hold, then let the consumer return credits
    task automatic releaseCredits(input int firstResult);
        if (holdCycles > 0) begin
            repeat (holdCycles) begin
                @(posedge clk);
                #DriveDelay;
            end
            if (gotRegs.size() - firstResult > ResultCredits) begin
                reportFailure("more results than result credits while credits were held");
            end
            holdCredits = 1'b0;
        end
    endtask

    task automatic waitForResults(input int target);
        int waited;
        waited = 0;
        while (!timedOut && gotRegs.size() < target) begin
            @(posedge clk);
            #DriveDelay;
            waited++;
            if (waited > WaitLimit) begin
                reportTimeout("expected results did not arrive");
            end
        end
    endtask

    // All words decoded, pipe empty, all result credits back
    task automatic waitForDrain();
        int waited;
        waited = 0;
        while (!timedOut && creditTotal != sentTotal) begin
            @(posedge clk);
            #DriveDelay;
            waited++;
            if (waited > WaitLimit) begin
                reportTimeout("instruction credits did not all return");
            end
        end
        repeat (PipeSettle) begin
            @(posedge clk);
            #DriveDelay;
        end
        waited = 0;
        while (!timedOut && returnsSeen != resultsTotal) begin
            @(posedge clk);
            #DriveDelay;
            waited++;
            if (waited > WaitLimit) begin
                reportTimeout("result credits did not all return");
            end
        end
    endtask

    task automatic runTest();
        int firstResult;
        int errorsBefore;
        int sentBefore;
        int creditsBefore;
        int gotCount;
        firstResult = gotRegs.size();
        errorsBefore = errorCount + protocolErrors;
        sentBefore = sentTotal;
        creditsBefore = creditTotal;
        holdCredits = (holdCycles > 0);
        fork
            sendWords();
            releaseCredits(firstResult);
        join
        waitForResults(firstResult + expRegs.size());
        // Every word of the test taken into decode by the last result
        if (!timedOut && creditTotal - creditsBefore != sentTotal - sentBefore) begin
            reportFailure("instruction credit count differs from words sent");
        end
        waitForDrain();
        gotCount = gotRegs.size() - firstResult;
        if (!timedOut) begin
            if (gotCount != expRegs.size()) begin
                reportFailure($sformatf("expected %0d results but got %0d",
                                        expRegs.size(), gotCount));
            end
            // Program order, one event per result
            for (int i = 0; i < expRegs.size() && i < gotCount; i++) begin
                checkReg($sformatf("resultReg[%0d]", i), expRegs[i], gotRegs[firstResult + i]);
                checkWord($sformatf("resultData[%0d]", i), expValues[i],
                          gotValues[firstResult + i]);
            end
        end
        testsRun++;
        if (errorCount + protocolErrors == errorsBefore) begin
            $display("test %0s passed, %0d results", testName, gotCount);
        end else begin
            testsFailed++;
            $display("test %0s FAILED", testName);
        end
    endtask

    initial begin
        int fd;
        int status;
        int regNum;
        logic [7:0] kind;
        logic [8*128-1:0] skipped;
        logic [WordWidth-1:0] word;
        logic [WordWidth-1:0] value;
        reset = 1'b1;
        instrValid = 1'b0;
        instr = '0;
        sentTotal = 0;
        holdCredits = 1'b0;
        timedOut = 1'b0;
        errorCount = 0;
        testsRun = 0;
        testsFailed = 0;
        holdCycles = 0;
        testName = '0;
        repeat (10) @(posedge clk);
        #DriveDelay;
        reset = 1'b0;

        fd = $fopen("testbench/coreTests.dat", "r");
        if (fd == 0) begin
            reportFailure("cannot open testbench/coreTests.dat");
        end else begin
            while (!timedOut && $fscanf(fd, "%s", kind) == 1) begin
                if (kind == "#") begin
                    status = $fgets(skipped, fd);
                    if (status == 0) begin
                        reportFailure("comment line in the data file could not be read");
                    end
                end else if (kind == "T") begin
                    status = $fscanf(fd, "%s %d", testName, holdCycles);
                    if (status != 2) begin
                        reportFailure("malformed test line in the data file");
                    end
                    instrList.delete();
                    expRegs.delete();
                    expValues.delete();
                end else if (kind == "I") begin
                    status = $fscanf(fd, "%h", word);
                    if (status != 1) begin
                        reportFailure("malformed instruction record in the data file");
                    end
                    instrList.push_back(word);
                end else if (kind == "R") begin
                    status = $fscanf(fd, "%d %h", regNum, value);
                    if (status != 2) begin
                        reportFailure("malformed result record in the data file");
                    end
                    expRegs.push_back(RegIdxWidth'(regNum));
                    expValues.push_back(value);
                end else if (kind == "E") begin
                    runTest();
                end else begin
                    reportFailure("unknown record kind in the data file");
                end
            end
            $fclose(fd);
        end

        $display("%0d tests run, %0d failed, %0d errors",
                 testsRun, testsFailed, errorCount + protocolErrors);
        if (errorCount + protocolErrors == 0 && !timedOut && testsRun > 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* testbench/coreTests.dat */
# T name holdCycles starts a test, result credits are withheld for holdCycles cycles
# I word is one instruction in hex, R reg value is the result it should produce
# E ends the test and runs it
T arith_r 0
I 20010007 R 1 00000007
I 2002FFFD R 2 FFFFFFFD
I 00221820 R 3 00000004
I 00412022 R 4 FFFFFFF6
I 0041282A R 5 00000001
I 0022302A R 6 00000000
E
T logic_shift 0
I 00223824 R 7 00000005
I 00244025 R 8 FFFFFFF7
I 00224826 R 9 FFFFFFFA
I 00015100 R 10 00000070
I 00025F02 R 11 0000000F
E
T immediates 0
I 202C8000 R 12 FFFF8007
I 304DF0F0 R 13 0000F0F0
I 340E8001 R 14 00008001
I 3C0FABCD R 15 ABCD0000
I 35EF1234 R 15 ABCD1234
E
T forward_chain 0
I 20100001 R 16 00000001
I 02108820 R 17 00000002
I 02309020 R 18 00000003
I 02519822 R 19 00000001
I 0013A0C0 R 20 00000008
E
T zero_and_unknown 0
I 20000005 R 0 00000005
I 0001A820 R 21 00000007
I FC000000
I 0000003F
I 20160055 R 22 00000055
E
T backpressure 40
I 20170011 R 23 00000011
I 22F80022 R 24 00000033
I 0317C820 R 25 00000044
I 233A0001 R 26 00000045
I 0357D826 R 27 00000054
I 0379E022 R 28 00000010
E
